// ==== verilog.f ====
verilog/dma_pkg.sv
verilog/dma_ifs.sv
verilog/dma_fifo.sv
verilog/dma_xfer_count.sv
verilog/dma_ctrl.sv
verilog/dma_top.sv
dv/dma_props.sv
dv/dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module dma_tb -o dma_sim

out=$(./obj_dir/dma_sim)
echo "$out"

# Passing run prints the pass line on its own
echo "$out" | grep -q "^No errors$"

// ==== dv/dma_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_tb;
	import dma_pkg::*;

	localparam int total_words = 69;                     // Word counts of all tests
	localparam int timeout_cyc = total_words * 40 + 300; // Plus reset and idle gaps

	logic        clk;
	logic        reset;
	addr_t       num_words;
	byte_addr_t  start_addr;
	logic        rd_wr;
	logic        rqst;
	logic        dev_ack;
	data_t       dev_in;
	logic        dma_ack;
	logic        end_flag;
	logic        xfer_error;
	data_t       dev_out;
	data_t       dma_in;
	logic        dma_ready;
	logic        dma_resp;
	addr_t       dma_addr;
	data_t       dma_out;
	logic        dma_en;
	logic [1:0]  dma_we;

	integer seed = 32'h803c6ddf;
	data_t  mem [0:(1 << addr_w)-1]; // Memory model
	data_t  wr_q [$];                // Device words of a write in order
	addr_t  base;                    // Word base of the running test
	logic   stall;                   // Random ready and ack gaps
	int     err_at;                  // Access number that answers with dma_resp
	int     rx_cnt;                  // Read words seen on dev_out
	int     wr_pos;                  // Next device word of a write
	int     acc_cnt;                 // Completed bus accesses
	int     en_seen;                 // Cycles with dma_en
	int     ack_seen;                // Cycles with dma_ack
	int     cyc = 0;
	int     t0;
	int     errors = 0;
	int     checks = 0;
	int     tests = 0;
	string  test_name;

	dma_top dut_i (.*);

	bind dma_top dma_props props_i
	(
		.clk       (clk),
		.reset     (reset),
		.dma_en    (dma_en),
		.dma_ready (dma_ready),
		.dma_we    (dma_we),
		.dma_addr  (dma_addr),
		.dma_ack   (dma_ack),
		.end_flag  (end_flag)
	);

	// Initial memory contents mix every address bit
	function automatic data_t ref_read(input addr_t a);
		return {a[7:0], a[15:8]} ^ 16'hc35a;
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	// ==========================================================================
	// Memory and device models
	// ==========================================================================

	// Inputs change 1 ns after each rising edge
	initial
	begin : bus_drive
		logic [31:0] r;
		forever
		begin
			@(posedge clk);
			#1;
			r = $random(seed);
			dma_ready = stall ? r[0] : 1'b1;
			dev_ack = stall ? (r[2:1] != 2'b00) : 1'b1;
			dma_in = mem[dma_addr];
			dma_resp = dma_en && (err_at == acc_cnt + 1); // Injected bus error
			dev_in = (wr_pos < wr_q.size()) ? wr_q[wr_pos] : '0;
		end
	end

	// Mid-cycle view of what the next edge completes
	initial
	begin : bus_observe
		forever
		begin
			@(negedge clk);
			if (dma_en && dma_ready)
			begin
				acc_cnt++;
				if (dma_we == write_mask && !dma_resp)
					mem[dma_addr] = dma_out; // Store lands at this edge
			end
			if (dma_ack && dev_ack && rd_wr != dir_read)
				wr_pos++; // Device word taken
			if (dma_en)
				en_seen++;
			if (dma_ack)
				ack_seen++;
		end
	end

	// Read data against the reference
	initial
	begin : compare
		data_t exp;
		forever
		begin
			@(negedge clk);
			if (dma_ack && dev_ack && rd_wr == dir_read)
			begin
				exp = ref_read(base + addr_t'(rx_cnt));
				checks++;
				assert (dev_out === exp)
				else
				begin
					$display("MISMATCH %s word %0d expected %h actual %h",
						test_name, rx_cnt, exp, dev_out);
					errors++;
				end
				rx_cnt++;
			end
		end
	end

	// ==========================================================================
	// Test tasks
	// ==========================================================================

	task automatic check_val(input string what, input int exp, input int act);
		checks++;
		assert (exp == act)
		else
		begin
			$display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	// One-cycle rqst with request inputs held through GET_REGS
	task automatic start_req(input int words, input int baddr, input logic dir);
		@(posedge clk);
		#1;
		num_words = addr_t'(words);
		start_addr = byte_addr_t'(baddr);
		rd_wr = dir;
		rqst = 1'b1;
		t0 = cyc;
		@(posedge clk);
		#1;
		rqst = 1'b0;
	endtask

	task automatic run_xfer(input string name, input int words, input int baddr,
		input logic dir, input logic stalls, input int bad_access, input logic exp_err,
		input int exp_lat);
		int   n;
		int   errs_before;
		logic err;
		errs_before = errors;
		@(negedge clk); // Clear of the drive process
		test_name = name;
		stall = stalls;
		err_at = bad_access;
		base = addr_t'(baddr >> 1);
		rx_cnt = 0;
		wr_pos = 0;
		acc_cnt = 0;
		en_seen = 0;
		ack_seen = 0;
		wr_q.delete();
		if (dir != dir_read)
			repeat (words) wr_q.push_back(data_t'($random(seed)));
		start_req(words, baddr, dir);
		n = 0;
		while (!end_flag && n < words * 40 + 20)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		err = xfer_error;
		if (!end_flag)
		begin
			$display("%s: end_flag did not arrive in time", name);
			errors++;
		end
		check_val("xfer_error", int'(exp_err), int'(err));
		if (exp_lat > 0)
			check_val("end latency", exp_lat, cyc - t0);
		if (words == 0)
			check_val("dma_en cycles", 0, en_seen); // No bus traffic
		if (bad_access > 0)
			check_val("dma_ack cycles", 0, ack_seen);
		if (dir == dir_read && !exp_err)
			check_val("words delivered", words, rx_cnt);
		if (dir != dir_read && !exp_err)
			for (int i = 0; i < words; i++)
				check_val($sformatf("mem[%h]", base + addr_t'(i)), int'(wr_q[i]),
					int'(mem[base + addr_t'(i)]));
		tests++;
		$display("%s: %s", name, (errors == errs_before) ? "ok" : "failed");
	endtask

	// ==========================================================================
	// Sequence
	// ==========================================================================

	initial
	begin : main
		reset = 1'b1;
		num_words = '0;
		start_addr = '0;
		rd_wr = dir_read;
		rqst = 1'b0;
		dev_ack = 1'b0;
		dev_in = '0;
		dma_in = '0;
		dma_ready = 1'b0;
		dma_resp = 1'b0;
		stall = 1'b0;
		err_at = 0;
		rx_cnt = 0;
		wr_pos = 0;
		acc_cnt = 0;
		for (int a = 0; a < (1 << addr_w); a++)
			mem[a] = ref_read(addr_t'(a));
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		test_name = "reset";
		check_val("outputs", 0, int'({dma_ack, dma_en, dma_we, end_flag, xfer_error}));

		run_xfer("read_5", 5, 'h0100, dir_read, 1'b0, 0, 1'b0, 0);
		run_xfer("write_16", 16, 'h0400, ~dir_read, 1'b0, 0, 1'b0, 0);
		run_xfer("read_stall", 5, 'h0100, dir_read, 1'b1, 0, 1'b0, 0);
		run_xfer("write_stall", 16, 'h0400, ~dir_read, 1'b1, 0, 1'b0, 0);
		run_xfer("zero_length", 0, 'h0100, dir_read, 1'b0, 0, 1'b0, 2);
		run_xfer("too_long", 17, 'h0100, dir_read, 1'b0, 0, 1'b1, 2);
		run_xfer("bus_error", 5, 'h0300, dir_read, 1'b0, 3, 1'b1, 0);
		run_xfer("read_after_error", 5, 'h0300, dir_read, 1'b0, 0, 1'b0, 0);

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(timeout_cyc * 4);
		$display("Timeout in test %s after %0d cycles", test_name, timeout_cyc);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/dma_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_props
(
	input logic           clk,
	input logic           reset,
	input logic           dma_en,
	input logic           dma_ready,
	input logic [1:0]     dma_we,
	input dma_pkg::addr_t dma_addr,
	input logic           dma_ack,
	input logic           end_flag
);

	// ==========================================================================
	// Memory bus handshake
	// ==========================================================================

	// Access held with the same address and strobes until dma_ready
	bus_hold: assert property (@(posedge clk) disable iff (reset)
		dma_en && !dma_ready |=> dma_en && $stable(dma_addr) && $stable(dma_we))
		else $error("bus access changed or dropped before dma_ready");

	// Device and memory phases never overlap
	phase_excl: assert property (@(posedge clk) disable iff (reset)
		!(dma_ack && dma_en))
		else $error("dma_ack and dma_en high in the same cycle");

	// ==========================================================================
	// End of transfer
	// ==========================================================================

	end_pulse: assert property (@(posedge clk) disable iff (reset)
		end_flag |=> !end_flag) // One cycle only
		else $error("end_flag held longer than one cycle");

endmodule

`default_nettype wire

// ==== verilog/dma_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_top
(
	input  logic                clk,
	input  logic                reset,
	// Device side
	input  dma_pkg::addr_t      num_words,
	input  dma_pkg::byte_addr_t start_addr,
	input  logic                rd_wr,
	input  logic                rqst,
	input  logic                dev_ack,
	input  dma_pkg::data_t      dev_in,
	output logic                dma_ack,
	output logic                end_flag,
	output logic                xfer_error,
	output dma_pkg::data_t      dev_out,
	// Memory bus side
	input  dma_pkg::data_t      dma_in,
	input  logic                dma_ready,
	input  logic                dma_resp,
	output dma_pkg::addr_t      dma_addr,
	output dma_pkg::data_t      dma_out,
	output logic                dma_en,
	output logic [1:0]          dma_we
);

	fifo_if  fi ();
	count_if ci ();

	// ==========================================================================
	// Blocks
	// ==========================================================================

	dma_ctrl ctrl_i
	(
		.clk        (clk),
		.reset      (reset),
		.rqst       (rqst),
		.rd_wr      (rd_wr),
		.dev_ack    (dev_ack),
		.dma_ready  (dma_ready),
		.dma_resp   (dma_resp),
		.dma_ack    (dma_ack),
		.dma_en     (dma_en),
		.end_flag   (end_flag),
		.xfer_error (xfer_error),
		.dma_we     (dma_we),
		.f          (fi.ctrl),
		.c          (ci.ctrl)
	);

	dma_fifo fifo_i (.clk(clk), .reset(reset), .f(fi.buffer), .dev_in(dev_in), .dma_in(dma_in));

	dma_xfer_count cnt_i
	(
		.clk        (clk),
		.reset      (reset),
		.c          (ci.cnt),
		.num_words  (num_words),
		.start_addr (start_addr),
		.dma_addr   (dma_addr)
	);

	// One consumer per phase, so both sides see the head
	assign dev_out = fi.head;
	assign dma_out = fi.head; // Qualified by dma_we

endmodule

`default_nettype wire

// ==== verilog/dma_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl
(
	input  logic       clk,
	input  logic       reset,
	input  logic       rqst,
	input  logic       rd_wr,      // High for a read
	input  logic       dev_ack,
	input  logic       dma_ready,
	input  logic       dma_resp,
	output logic       dma_ack,
	output logic       dma_en,
	output logic       end_flag,
	output logic       xfer_error,
	output logic [1:0] dma_we,
	fifo_if.ctrl       f,
	count_if.ctrl      c
);
	import dma_pkg::*;

	state_e state;
	state_e next_state;
	logic   err_q;    // Held into DONE
	logic   to_mem_q; // Write transfer in flight
	logic   mem_done; // Bus access completes this edge
	logic   mem_ok;   // Completes without error
	logic   dev_done; // Device word moves this edge

	// ==========================================================================
	// Handshake decode
	// ==========================================================================

	assign mem_done = dma_en & dma_ready;
	assign mem_ok = mem_done & ~dma_resp;
	assign dev_done = dma_ack & dev_ack;

	// ==========================================================================
	// State register and next state
	// ==========================================================================

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state; // Hold by default
		case (state)
			IDLE:
				if (rqst)
					next_state = GET_REGS;
			GET_REGS:
				if (c.is_zero || c.too_long)
					next_state = DONE; // Nothing to move
				else if (rd_wr == dir_read)
					next_state = LOAD_MEM;
				else
					next_state = DEV_RECV;
			LOAD_MEM:
				next_state = MEM_READ;
			MEM_READ:
				if (mem_done && dma_resp)
					next_state = ABORT;
				else if (mem_ok && c.last)
					next_state = DEV_SEND; // FIFO holds all words
			DEV_SEND:
				if (dev_done && c.last)
					next_state = DONE;
			DEV_RECV:
				if (dev_done && c.last)
					next_state = MEM_WRITE;
			MEM_WRITE:
				if (mem_done && dma_resp)
					next_state = ABORT;
				else if (mem_ok && c.last)
					next_state = DONE;
			ABORT:
				next_state = DONE;
			DONE:
				next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	// ==========================================================================
	// Transfer flags
	// ==========================================================================

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			err_q <= 1'b0;
			to_mem_q <= 1'b0;
		end
		else if (state == GET_REGS)
		begin
			err_q <= c.too_long; // Rejected length
			to_mem_q <= (rd_wr != dir_read);
		end
		else if (mem_done && dma_resp)
			err_q <= 1'b1; // Bus error
	end

	// Outputs
	assign dma_ack = (state == DEV_SEND) || (state == DEV_RECV);
	assign dma_en = (state == MEM_READ) || (state == MEM_WRITE);
	assign dma_we = (state == MEM_WRITE) ? write_mask : 2'b00;
	assign end_flag = (state == DONE);
	assign xfer_error = (state == DONE) & err_q;

	// FIFO strobes
	assign f.clear = (state == GET_REGS) || (state == ABORT);
	assign f.push = ((state == MEM_READ) && mem_ok) || ((state == DEV_RECV) && dev_done);
	assign f.pop = ((state == DEV_SEND) && dev_done) || ((state == MEM_WRITE) && mem_ok);
	assign f.to_mem = to_mem_q;

	// Counter strobes, one step per completed handshake
	assign c.load = (state == GET_REGS);
	assign c.step = mem_ok | dev_done;

endmodule

`default_nettype wire

// ==== verilog/dma_xfer_count.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_xfer_count
(
	input  logic               clk,
	input  logic               reset,
	count_if.cnt               c,
	input  dma_pkg::addr_t     num_words,
	input  dma_pkg::byte_addr_t start_addr,
	output dma_pkg::addr_t     dma_addr
);
	import dma_pkg::*;

	// ==========================================================================
	// Request registers
	// ==========================================================================

	addr_t len;     // Requested word count
	addr_t base;    // Start word address
	idx_t  idx;     // Word within the current phase
	addr_t len_now; // Length seen by the flags

	// Requested length feeds the flags
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			len <= '0;
		else if (c.load)
			len <= num_words;
	end

	// Byte address halved to a word address
	always_ff @(posedge clk)
	begin
		if (c.load)
			base <= start_addr[addr_w:1];
	end

	// Index wraps to zero after the last word
	// So each phase starts again from the base
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			idx <= '0;
		else if (c.load)
			idx <= '0;
		else if (c.step)
			idx <= c.last ? '0 : idx + idx_t'(1);
	end

	// ==========================================================================
	// Address and flags
	// ==========================================================================

	assign dma_addr = base + addr_t'(idx);

	// While loading, flags look at the incoming request
	// Lets GET_REGS decide in one cycle
	assign len_now = c.load ? num_words : len;

	assign c.is_zero = (len_now == '0);
	assign c.too_long = (len_now > addr_t'(fifo_words));

	// Final word of a phase
	assign c.last = (addr_t'(idx) == len - addr_t'(1));

endmodule

`default_nettype wire

// ==== verilog/dma_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_fifo
(
	input  logic           clk,
	input  logic           reset,
	fifo_if.buffer         f,
	input  dma_pkg::data_t dev_in,
	input  dma_pkg::data_t dma_in
);
	import dma_pkg::*;

	// ==========================================================================
	// Storage and pointers
	// ==========================================================================

	data_t                mem [fifo_words]; // Word storage
	logic [fifo_log2-1:0] wr_ptr;          // Wraps at fifo_words
	logic [fifo_log2-1:0] rd_ptr;
	idx_t                 count;           // 0 to fifo_words
	data_t                wr_data;
	logic                 do_push;
	logic                 do_pop;

	// Input steering
	// Writes take device words, reads take bus words
	assign wr_data = f.to_mem ? dev_in : dma_in;

	// Guard against overrun and underrun
	assign do_push = f.push & ~f.full;
	assign do_pop = f.pop & ~f.empty;

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= wr_data;
	end

	// Pointer and count update
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (f.clear)
		begin
			wr_ptr <= '0; // Drop anything left over
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + idx_t'(1);
				2'b01:   count <= count - idx_t'(1);
				default: count <= count; // Both or neither
			endcase
		end
	end

	// ==========================================================================
	// Flags and head
	// ==========================================================================

	assign f.full = (count == idx_t'(fifo_words));
	assign f.empty = (count == '0);

	// Asynchronous head read follows rd_ptr
	assign f.head = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== verilog/dma_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// ==========================================================================
// Controller to word FIFO
// ==========================================================================

interface fifo_if;
	import dma_pkg::*;

	logic  clear;  // Empty the FIFO
	logic  push;   // Store one word this edge
	logic  pop;    // Drop the head this edge
	logic  to_mem; // Write transfer with the device feeding the FIFO
	logic  full;
	logic  empty;
	data_t head;   // Oldest word while not empty

	modport ctrl
	(
		output clear, push, pop, to_mem,
		input  full, empty
	);

	modport buffer
	(
		input  clear, push, pop, to_mem,
		output full, empty, head
	);

endinterface

// ==========================================================================
// Controller to transfer counter
// ==========================================================================

interface count_if;
	logic load;     // Capture length and base and zero the index
	logic step;     // One word done
	logic is_zero;  // Zero-length request
	logic too_long; // More than the FIFO holds
	logic last;     // Index on the final word

	modport ctrl
	(
		output load, step,
		input  is_zero, too_long, last
	);

	modport cnt
	(
		input  load, step,
		output is_zero, too_long, last
	);

endinterface

`default_nettype wire

// ==== verilog/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

	// ==========================================================================
	// Bus and FIFO sizes
	// ==========================================================================

	localparam int addr_w = 16;                 // Word address on the memory bus
	localparam int data_w = 16;                 // One bus word
	localparam int fifo_log2 = 4;               // FIFO depth exponent
	localparam int fifo_words = 1 << fifo_log2; // Also the longest legal transfer

	// Byte enables for a full-word store
	localparam logic [1:0] write_mask = 2'b11;

	// ==========================================================================
	// Types
	// ==========================================================================

	// Memory side addresses count words
	typedef logic [addr_w-1:0] addr_t;

	// Device byte address is one bit wider than the word address
	typedef logic [addr_w:0] byte_addr_t;

	typedef logic [data_w-1:0] data_t;

	// One extra bit so the index can reach fifo_words
	typedef logic [fifo_log2:0] idx_t;

	// ==========================================================================
	// Controller states
	// ==========================================================================

	typedef enum logic [3:0]
	{
		IDLE,      // Waiting for rqst
		GET_REGS,  // Request registers captured
		LOAD_MEM,  // Bus setup before the first read
		MEM_READ,  // Memory words into the FIFO
		DEV_SEND,  // FIFO words out to the device
		DEV_RECV,  // Device words into the FIFO
		MEM_WRITE, // FIFO words out to memory
		ABORT,     // Bus error seen
		DONE       // end_flag cycle
	} state_e;

	// Read direction seen on rd_wr
	localparam logic dir_read = 1'b1;

endpackage

`default_nettype wire
